// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // word and bus sizes
    localparam int data_width = 32;                         // data and address word
    localparam int ctrl_width = 2;                          // mem_control word
    localparam int resp_width = 2;                          // axi bresp field

    // data ram
    localparam int ram_depth_log = 14;                      // 16K words
    localparam int ram_depth     = 1 << ram_depth_log;      // 64 KB of words
    localparam int word_lsb      = 2;                       // byte addr to word addr shift

    // io window sits at the very top of the address space
    localparam int io_low_bit    = 10;                      // lowest bit of window compare
    localparam int io_high_width = data_width - io_low_bit; // bits 31..10
    localparam logic [io_high_width-1:0] io_high_addr = '1; // all ones marks io
    localparam int io_type_bit   = 4;                       // 0 keypad, 1 display

    // mem_control bit positions
    localparam int mem_read_bit  = 0;                       // load request
    localparam int mem_write_bit = 1;                       // store request

    // loader address flag for instruction space
    localparam int imem_flag_bit = 16;                      // writes here get dropped

    // keypad settle stall
    localparam int settle_cycles    = 4;                    // stall length
    localparam int settle_cnt_width = $clog2(settle_cycles + 1);

    // axi response codes
    localparam logic [resp_width-1:0] resp_okay = 2'b00;    // okay

endpackage

`default_nettype wire

// File: design/ram_block.sv
`timescale 1ns/1ps
`default_nettype none

// single port word ram, registered read, read-before-write
module ram_block (
    input  wire                              clk,
    input  wire                              en,       // port enable
    input  wire                              we,       // write enable, only with en
    input  wire [mem_pkg::ram_depth_log-1:0] addr,     // word address
    input  wire [mem_pkg::data_width-1:0]    din,      // write word
    output logic [mem_pkg::data_width-1:0]   dout      // read word, one cycle late
);
    import mem_pkg::*;

    logic [data_width-1:0] mem [ram_depth];             // inferred block ram

    always_ff @(posedge clk) begin
        if (en) begin                                   // idle port keeps dout
            if (we) begin
                mem[addr] <= din;                       // store on this edge
            end
            dout <= mem[addr];                          // old word on collision
        end
    end

endmodule

`default_nettype wire

// File: design/settle_timer.sv
`timescale 1ns/1ps
`default_nettype none

// keypad settle stall
// start loads the counter, stall holds while it runs down
module settle_timer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  start,                                 // keypad read request
    output logic stall,                                 // freeze the processor
    output logic done                                   // sample the keypad now
);
    import mem_pkg::*;

    logic [settle_cnt_width-1:0] count;                 // cycles left
    logic                        done_q;                // read just finished

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= done;
            if (count != '0) begin
                count <= count - 1'b1;                  // running, start ignored
            end else if (start && !done_q) begin
                // the finished request is still on the bus for one cycle
                count <= settle_cycles[settle_cnt_width-1:0];
            end
        end
    end

    assign stall = (count != '0);
    assign done  = (count == 1);                        // last stall cycle

endmodule

`default_nettype wire

// File: design/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

// io port registers
// display value written by stores, keypad sampled at end of settle
module io_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            vga_we,      // display store strobe
    input  wire  [mem_pkg::data_width-1:0] store_data,  // store word
    output logic [mem_pkg::data_width-1:0] vga_value,   // to display driver
    input  wire                            settle_done, // keypad is stable
    input  wire  [mem_pkg::data_width-1:0] keypad_data, // raw keypad word
    output logic [mem_pkg::data_width-1:0] kbd_value    // sampled keypad word
);

    // display register, blank after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_value <= '0;
        end else if (vga_we) begin
            vga_value <= store_data;                    // shows up next cycle
        end
    end

    // keypad sample, taken on the last stall cycle
    always_ff @(posedge clk) begin
        if (settle_done) begin
            kbd_value <= keypad_data;                   // ready when stall drops
        end
    end

endmodule

`default_nettype wire

// File: design/load_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// axi4-lite write slave for program loading
// one write in flight, address and data may come in either order
module load_ctrl (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            load_en,     // loader mode
    input  wire                            awvalid,
    output logic                           awready,
    input  wire [mem_pkg::data_width-1:0]  awaddr,
    input  wire                            wvalid,
    output logic                           wready,
    input  wire [mem_pkg::data_width-1:0]  wdata,
    output logic                           bvalid,
    input  wire                            bready,
    output logic [mem_pkg::resp_width-1:0] bresp,
    output logic                           loader_we,   // ram write pulse
    output logic [mem_pkg::data_width-1:0] loader_addr, // latched byte address
    output logic [mem_pkg::data_width-1:0] loader_data  // latched word
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,                                        // waiting for aw and w
        st_write,                                       // ram write cycle
        st_resp                                         // holding bvalid
    } state_t;

    state_t                state;
    logic                  aw_got;                      // address already taken
    logic                  w_got;                       // data already taken
    logic                  aw_hs;
    logic                  w_hs;
    logic [data_width-1:0] addr_q;
    logic [data_width-1:0] data_q;

    // both ready together in idle, each drops once its beat is in
    assign awready = load_en & (state == st_idle) & ~aw_got;
    assign wready  = load_en & (state == st_idle) & ~w_got;
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if ((aw_got | aw_hs) & (w_got | w_hs)) begin
                        state  <= st_write;             // both beats in hand
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                    end else begin
                        aw_got <= aw_got | aw_hs;       // remember a lone beat
                        w_got  <= w_got | w_hs;
                    end
                end
                st_write: begin
                    state <= st_resp;                   // write happens this cycle
                end
                st_resp: begin
                    if (bready) begin
                        state <= st_idle;               // master took the response
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            addr_q <= awaddr;
        end
        if (w_hs) begin
            data_q <= wdata;
        end
    end

    // instruction space writes are acked but dropped
    assign loader_we   = (state == st_write) & ~addr_q[imem_flag_bit];
    assign loader_addr = addr_q;
    assign loader_data = data_q;

    assign bvalid = (state == st_resp);
    assign bresp  = resp_okay;                          // never an error

endmodule

`default_nettype wire

// File: design/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

// data memory front end
// decodes each processor access to ram, keypad or display and
// hands the ram port to the loader while load_en is high
module data_mem (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           load_en,      // loader owns the ram
    input  wire                           no_op,        // bubble, no access
    input  wire [mem_pkg::ctrl_width-1:0] mem_control,  // read and write request bits
    input  wire [mem_pkg::data_width-1:0] mem_addr,     // byte address
    input  wire [mem_pkg::data_width-1:0] store_data,   // store word
    output logic [mem_pkg::data_width-1:0] read_data,   // load result
    input  wire                           loader_we,    // loader write strobe
    input  wire [mem_pkg::data_width-1:0] loader_addr,  // loader byte address
    input  wire [mem_pkg::data_width-1:0] loader_data,  // loader word
    input  wire [mem_pkg::data_width-1:0] kbd_value,    // settled keypad sample
    output logic                          kbd_start,    // kick the settle timer
    output logic                          vga_we,       // display register load
    output logic                          input_active  // keypad read in progress
);
    import mem_pkg::*;

    logic                     io_active;                // address in io window
    logic                     proc_en;                  // processor may access
    logic                     proc_rd;                  // live load
    logic                     proc_wr;                  // live store
    logic                     kbd_rd;                   // load from keypad port
    logic                     ram_en;
    logic                     ram_we;
    logic [ram_depth_log-1:0] ram_addr;
    logic [data_width-1:0]    ram_din;
    logic [data_width-1:0]    ram_dout;
    logic                     sel_kbd_q;                // last cycle was a keypad read

    // address decode
    assign io_active = (mem_addr[data_width-1:io_low_bit] == io_high_addr);
    assign proc_en   = ~no_op & ~load_en;               // loader blocks the processor
    assign proc_rd   = proc_en & mem_control[mem_read_bit];
    assign proc_wr   = proc_en & mem_control[mem_write_bit];

    // io strobes, bit 4 picks the port
    assign kbd_rd       = proc_rd & io_active & ~mem_addr[io_type_bit];
    assign vga_we       = proc_wr & io_active & mem_addr[io_type_bit];
    assign kbd_start    = kbd_rd;                       // timer drops repeats itself
    assign input_active = kbd_rd;                       // request held through the stall

    // ram port mux, loader first
    always_comb begin
        if (load_en) begin
            ram_en   = loader_we;                       // only touch ram on a write
            ram_we   = loader_we;
            ram_addr = loader_addr[ram_depth_log+word_lsb-1:word_lsb];
            ram_din  = loader_data;
        end else begin
            ram_en   = (proc_rd | proc_wr) & ~io_active; // io never hits ram
            ram_we   = proc_wr & ~io_active;             // aliased word left alone
            ram_addr = mem_addr[ram_depth_log+word_lsb-1:word_lsb];
            ram_din  = store_data;
        end
    end

    ram_block u_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (ram_we),
        .addr (ram_addr),
        .din  (ram_din),
        .dout (ram_dout)
    );

    // read select follows the ram latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_kbd_q <= 1'b0;
        end else begin
            sel_kbd_q <= kbd_rd;                        // keypad wins next cycle
        end
    end

    assign read_data = sel_kbd_q ? kbd_value : ram_dout;

endmodule

`default_nettype wire

// File: design/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

// memory stage top, processor port, loader bus and io ports
module mem_subsystem (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            load_en,      // program load mode
    // processor side
    input  wire                            no_op,
    input  wire  [mem_pkg::ctrl_width-1:0] mem_control,
    input  wire  [mem_pkg::data_width-1:0] mem_addr,
    input  wire  [mem_pkg::data_width-1:0] store_data,
    output logic [mem_pkg::data_width-1:0] read_data,
    output logic                           stall,
    // loader axi4-lite write
    input  wire                            awvalid,
    output logic                           awready,
    input  wire  [mem_pkg::data_width-1:0] awaddr,
    input  wire                            wvalid,
    output logic                           wready,
    input  wire  [mem_pkg::data_width-1:0] wdata,
    output logic                           bvalid,
    input  wire                            bready,
    output logic [mem_pkg::resp_width-1:0] bresp,
    // io ports
    input  wire  [mem_pkg::data_width-1:0] keypad_data,
    output logic [mem_pkg::data_width-1:0] vga_value,
    output logic                           input_active
);
    import mem_pkg::*;

    logic                  loader_we;                   // loader to ram
    logic [data_width-1:0] loader_addr;
    logic [data_width-1:0] loader_data;
    logic                  kbd_start;                   // keypad read seen
    logic                  vga_we;                      // display store seen
    logic [data_width-1:0] kbd_value;                   // sampled keypad
    logic                  settle_done;                 // sample strobe

    load_ctrl u_load_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .loader_we   (loader_we),
        .loader_addr (loader_addr),
        .loader_data (loader_data)
    );

    data_mem u_data_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_en      (load_en),
        .no_op        (no_op),
        .mem_control  (mem_control),
        .mem_addr     (mem_addr),
        .store_data   (store_data),
        .read_data    (read_data),
        .loader_we    (loader_we),
        .loader_addr  (loader_addr),
        .loader_data  (loader_data),
        .kbd_value    (kbd_value),
        .kbd_start    (kbd_start),
        .vga_we       (vga_we),
        .input_active (input_active)
    );

    settle_timer u_settle_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (kbd_start),
        .stall (stall),
        .done  (settle_done)
    );

    io_regs u_io_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .vga_we      (vga_we),
        .store_data  (store_data),
        .vga_value   (vga_value),
        .settle_done (settle_done),
        .keypad_data (keypad_data),
        .kbd_value   (kbd_value)
    );

endmodule

`default_nettype wire

// File: dv/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the memory stage top
module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int load_count  = 150;                   // loader writes
    localparam int op_count    = 600;                   // random processor ops
    localparam int kbd_count   = 8;                     // keypad reads
    localparam int cycle_limit = 4000;                  // roughly twice the run length
    localparam logic [data_width-1:0] kbd_addr  = 32'hffff_fc00;  // io window with bit 4 clear
    localparam logic [data_width-1:0] vga_addr  = 32'hffff_fc10;  // io window with bit 4 set
    localparam logic [data_width-1:0] vga_alias = 32'h0000_fc10;  // ram word under vga_addr

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  load_en;
    logic                  no_op;
    logic [ctrl_width-1:0] mem_control;
    logic [data_width-1:0] mem_addr;
    logic [data_width-1:0] store_data;
    logic [data_width-1:0] read_data;
    logic                  stall;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    logic [data_width-1:0] wdata;
    logic                  bvalid;
    logic                  bready;
    logic [resp_width-1:0] bresp;
    logic [data_width-1:0] keypad_data;
    logic [data_width-1:0] vga_value;
    logic                  input_active;

    logic [data_width-1:0] ref_mem [int];               // ram model keyed by word index
    int                    used[$];                     // words holding known data
    int                    check_errors = 0;
    int                    prop_errors = 0;
    int                    cycles = 0;

    // request decode from the memory map
    wire proc_live = !load_en && !no_op;
    wire in_io     = (mem_addr[31:10] == '1);
    wire vga_req   = proc_live && mem_control[mem_write_bit] && in_io && mem_addr[io_type_bit];
    wire kbd_req   = proc_live && mem_control[mem_read_bit] && in_io && !mem_addr[io_type_bit];
    wire both_hs   = awvalid && awready && wvalid && wready;

    mem_subsystem uut (.*);

    always #20 clk = ~clk;                              // 40 ns period

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic report_property_failure(input string what);
        prop_errors++;
        $display("%s", what);
    endtask

    // reset state and loader gating
    assert property (@(posedge clk) !rst_n |=> (!stall && !bvalid && vga_value == '0))
        else report_property_failure("outputs not idle after reset");
    assert property (@(posedge clk) !load_en |-> (!awready && !wready))
        else report_property_failure("loader ready while load_en low");

    // axi write response timing
    assert property (@(posedge clk) disable iff (!rst_n) $past(both_hs, 2) |-> $rose(bvalid))
        else report_property_failure("bvalid did not rise 2 cycles after handshake");
    assert property (@(posedge clk) disable iff (!rst_n) (bvalid && !bready) |=> bvalid)
        else report_property_failure("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (!rst_n) bvalid |-> bresp == resp_okay)
        else report_property_failure("bresp was not okay");

    // display store lands one cycle later
    assert property (@(posedge clk) disable iff (!rst_n)
                     $past(vga_req) |-> vga_value == $past(store_data))
        else report_property_failure("vga_value not updated one cycle after store");

    // keypad stall shape
    assert property (@(posedge clk) disable iff (!rst_n) $rose(stall) |-> $past(kbd_req))
        else report_property_failure("stall rose without a keypad read");
    assert property (@(posedge clk) disable iff (!rst_n)
                     $fell(stall) |-> ($past(stall, 2) && $past(stall, 3) &&
                                       $past(stall, 4) && !$past(stall, 5)))
        else report_property_failure("stall length differs from settle_cycles");
    assert property (@(posedge clk) disable iff (!rst_n) stall |-> input_active)
        else report_property_failure("input_active low during keypad stall");

    task automatic compare_word(input string name, input logic [data_width-1:0] expected,
                                input logic [data_width-1:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [data_width-1:0] byte_of(input int w);
        return {16'h0, w[13:0], 2'b00};                 // word index back to byte address
    endfunction

    function automatic logic [data_width-1:0] rand_ram_addr();
        return {16'h0, 14'($urandom), 2'b00};           // below the io window
    endfunction

    task automatic note_write(input logic [data_width-1:0] addr,
                              input logic [data_width-1:0] data);
        int w;
        w = int'(addr[15:2]);                           // ram word index
        if (!ref_mem.exists(w)) begin
            used.push_back(w);
        end
        ref_mem[w] = data;
    endtask

    task automatic idle_bus();
        no_op       = 1'b0;
        mem_control = 2'b00;
    endtask

    // all bus tasks start and end just after a falling edge
    task automatic axi_write(input logic [data_width-1:0] addr,
                             input logic [data_width-1:0] data);
        int lat;
        int hold;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!(awready && wready)) begin
            @(negedge clk);                             // readies are stable here
        end
        @(negedge clk);                                 // handshake edge passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        lat = 1;
        while (!bvalid && lat < 10) begin
            @(negedge clk);
            lat++;
        end
        compare_word("axi_latency", 2, lat);
        hold = $urandom_range(0, 3);                    // back-pressure
        repeat (hold) @(negedge clk);
        compare_word("axi_bvalid_hold", 1, 32'(bvalid));
        compare_word("axi_bresp", 32'(resp_okay), 32'(bresp));
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        compare_word("axi_bvalid_drop", 0, 32'(bvalid));
    endtask

    task automatic proc_store(input logic [data_width-1:0] addr,
                              input logic [data_width-1:0] data, input logic bubble);
        no_op       = bubble;
        mem_control = 2'b10;
        mem_addr    = addr;
        store_data  = data;
        @(negedge clk);
        idle_bus();
    endtask

    task automatic proc_load(input logic [data_width-1:0] addr,
                             output logic [data_width-1:0] data);
        no_op       = 1'b0;
        mem_control = 2'b01;
        mem_addr    = addr;
        @(negedge clk);                                 // one cycle read latency
        data = read_data;
        idle_bus();
    endtask

    initial begin
        logic [data_width-1:0] got;
        logic [data_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [data_width-1:0] kbd_word;
        int w;
        int n;
        void'($urandom(17));
        rst_n       = 1'b0;
        load_en     = 1'b0;
        no_op       = 1'b0;
        mem_control = 2'b00;
        mem_addr    = '0;
        store_data  = '0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        bready      = 1'b0;
        keypad_data = '0;
        repeat (5) @(negedge clk);                      // 5 reset cycles
        rst_n = 1'b1;
        @(negedge clk);

        // reset state
        compare_word("reset_stall", 0, 32'(stall));
        compare_word("reset_bvalid", 0, 32'(bvalid));
        compare_word("reset_input_active", 0, 32'(input_active));
        compare_word("reset_vga_value", 0, vga_value);
        compare_word("reset_awready", 0, 32'(awready));

        // program load over axi then read back
        load_en = 1'b1;
        @(negedge clk);
        for (int i = 0; i < load_count; i++) begin
            addr = rand_ram_addr();
            data = $urandom;
            axi_write(addr, data);
            note_write(addr, data);
        end
        load_en = 1'b0;
        @(negedge clk);
        foreach (used[i]) begin
            proc_load(byte_of(used[i]), got);
            compare_word("load_readback", ref_mem[used[i]], got);
        end

        // random processor traffic against the model
        for (int i = 0; i < op_count; i++) begin
            case ($urandom_range(0, 2))
                0: begin
                    addr = rand_ram_addr();
                    data = $urandom;
                    proc_store(addr, data, 1'b0);
                    note_write(addr, data);
                end
                1: begin
                    w = used[$urandom_range(0, used.size() - 1)];
                    proc_load(byte_of(w), got);
                    compare_word("proc_load", ref_mem[w], got);
                end
                default: begin
                    w = used[$urandom_range(0, used.size() - 1)];
                    proc_store(byte_of(w), ~ref_mem[w], 1'b1);  // bubble store must not land
                    proc_load(byte_of(w), got);
                    compare_word("noop_store", ref_mem[w], got);
                end
            endcase
        end

        // display store leaves the aliased ram word untouched
        data = $urandom;
        proc_store(vga_alias, data, 1'b0);
        note_write(vga_alias, data);
        data = $urandom;
        proc_store(vga_addr, data, 1'b0);
        compare_word("vga_value", data, vga_value);
        proc_load(vga_alias, got);
        compare_word("vga_alias", ref_mem[int'(vga_alias[15:2])], got);

        // keypad reads with settle stall
        for (int i = 0; i < kbd_count; i++) begin
            keypad_data = $urandom;                     // still bouncing
            no_op       = 1'b0;
            mem_control = 2'b01;
            mem_addr    = kbd_addr;
            @(negedge clk);
            kbd_word    = $urandom;
            keypad_data = kbd_word;                     // settled value
            n = 0;
            while (stall && n < 20) begin
                n++;
                @(negedge clk);
            end
            compare_word("kbd_stall_len", settle_cycles, n);
            compare_word("kbd_read", kbd_word, read_data);
            @(negedge clk);                             // load retires on this edge
            idle_bus();
            @(negedge clk);                             // gap between reads
        end

        // instruction space write is acked and dropped
        w = used[0];
        load_en = 1'b1;
        @(negedge clk);
        axi_write(byte_of(w) | (32'h1 << imem_flag_bit), ~ref_mem[w]);
        load_en = 1'b0;
        @(negedge clk);
        proc_load(byte_of(w), got);
        compare_word("imem_write_dropped", ref_mem[w], got);

        repeat (2) @(negedge clk);
        $display("errors: %0d value checks, %0d property checks", check_errors, prop_errors);
        if (check_errors == 0 && prop_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/mem_pkg.sv
design/ram_block.sv
design/settle_timer.sv
design/io_regs.sv
design/load_ctrl.sv
design/data_mem.sv
design/mem_subsystem.sv
dv/tb_mem_subsystem.sv

// File: Makefile
SRCS := $(shell grep -v '^+' verilog.f)
BIN  := obj_dir/Vtb_mem_subsystem

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "PASS: all tests" sim.log

$(BIN): verilog.f $(SRCS)
	verilator --binary --timing --assert -f verilog.f \
		--top-module tb_mem_subsystem -o Vtb_mem_subsystem

clean:
	rm -rf obj_dir sim.log
